// ==== rtl/gobou_core.sv ====
`timescale 1ns/10ps
`include "gobou_params.svh"

module gobou_core
  import gobou_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  logic      net_we,
  input  net_addr_t net_addr,
  input  data_t     write_net,
  input  data_t     img_data,
  input  logic      start,
  input  logic      valid,
  input  logic      stop,
  output data_t     result,
  output logic      result_ready
);

  data_t r_wmem [2**`GOBOU_NETSIZE];
  data_t r_weight;
  acc_t  r_acc;
  logic  r_ready;

  always_ff @(posedge clk) begin
    if (net_we) begin
      r_wmem[net_addr] <= write_net;
    end
    r_weight <= r_wmem[net_addr];
  end

  // The bias word is aligned to the fraction point of the products.
  always_ff @(posedge clk) begin
    if (start) begin
      r_acc <= '0;
    end else if (valid && stop) begin
      r_acc <= r_acc + (acc_t'(r_weight) <<< `GOBOU_FRAC);
    end else if (valid) begin
      r_acc <= r_acc + img_data * r_weight;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_ready <= 1'b0;
    end else begin
      r_ready <= valid && stop;
    end
  end

  // Wraps on overflow.
  assign result       = data_t'(r_acc >>> `GOBOU_FRAC);
  assign result_ready = r_ready;

endmodule

// ==== rtl/gobou_ctrl.sv ====
`timescale 1ns/10ps
`include "gobou_params.svh"

module gobou_ctrl
  import gobou_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  logic      req,
  input  logic      img_we,
  input  img_addr_t input_addr,
  input  img_addr_t output_addr,
  input  data_t     write_img,
  input  data_t     write_result,
  input  logic      result_ready,
  input  core_sel_t net_we,
  input  net_addr_t net_addr,
  input  data_t     write_net,
  input  len_t      total_in,
  input  len_t      total_out,
  output logic      ack,
  output logic      mem_img_we,
  output img_addr_t mem_img_addr,
  output data_t     write_mem_img,
  output core_we_t  mem_net_we,
  output net_addr_t mem_net_addr,
  output data_t     write_mem_net,
  output logic      core_start,
  output logic      core_valid,
  output logic      core_stop
);

  ctrl_state_t             r_state;
  len_t                    r_total_in;
  len_t                    r_total_out;
  len_t                    r_count_in;
  len_t                    r_count_out;
  img_addr_t               r_input_offset;
  img_addr_t               r_output_offset;
  img_addr_t               r_output_cnt;
  net_addr_t               r_net_offset;
  net_addr_t               r_net_cnt;
  logic                    r_ack;
  logic                    r_img_we;
  data_t                   r_write_img;
  core_we_t                r_net_we;
  core_we_t                net_we_dec;
  data_t                   r_write_net;
  logic                    r_core_start;
  logic                    r_core_valid;
  logic                    r_core_stop;
  logic                    r_serial_we;
  logic [`GOBOU_CORELOG:0] r_serial_cnt;

  logic run_req;
  logic last_in;
  logic last_group;
  logic wb_active;
  logic s_output_end;

  assign run_req      = req && r_ack;
  assign last_in      = r_count_in == r_total_in - len_t'(1);
  assign last_group   = r_count_out + `GOBOU_CORE >= r_total_out;
  assign s_output_end = r_state == s_output && r_serial_cnt == `GOBOU_CORE;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state     <= s_wait;
      r_count_in  <= '0;
      r_count_out <= '0;
    end else begin
      case (r_state)
        s_wait: begin
          if (run_req) r_state <= s_weight;
        end
        s_weight: begin
          if (last_in) begin
            r_state    <= s_bias;
            r_count_in <= '0;
          end else begin
            r_count_in <= r_count_in + len_t'(1);
          end
        end
        s_bias: r_state <= s_output;
        s_output: begin
          if (s_output_end) begin
            if (last_group) begin
              r_state     <= s_wait;
              r_count_out <= '0;
            end else begin
              r_state     <= s_weight;
              r_count_out <= r_count_out + len_t'(`GOBOU_CORE);
            end
          end
        end
        default: r_state <= s_wait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_total_in  <= '0;
      r_total_out <= '0;
    end else if (r_state == s_wait && run_req) begin
      r_total_in  <= total_in;
      r_total_out <= total_out;
    end
  end

  // Offsets follow the host while idle and freeze once a run starts.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_input_offset  <= '0;
      r_output_offset <= '0;
      r_net_offset    <= '0;
    end else if (r_ack || req) begin
      r_input_offset  <= input_addr;
      r_output_offset <= output_addr;
      r_net_offset    <= net_addr;
    end
  end

  ////////////////////////////////////////
  // Image memory.
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_img_we <= 1'b0;
    end else begin
      r_img_we <= r_ack && img_we;
    end
  end

  always_ff @(posedge clk) begin
    r_write_img <= write_img;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_serial_we  <= 1'b0;
      r_serial_cnt <= '0;
    end else begin
      r_serial_we <= result_ready;
      if (r_serial_we) begin
        r_serial_cnt <= 1;
      end else if (r_serial_cnt == `GOBOU_CORE) begin
        r_serial_cnt <= '0;
      end else if (r_serial_cnt != 0) begin
        r_serial_cnt <= r_serial_cnt + 1'b1;
      end
    end
  end

  // Write-back runs for CORE cycles from the first serialized word.
  assign wb_active = r_serial_we || (r_serial_cnt != 0 && r_serial_cnt < `GOBOU_CORE);

  always_ff @(posedge clk) begin
    if (!xrst || r_state == s_wait) begin
      r_output_cnt <= '0;
    end else if (r_state == s_output && wb_active) begin
      r_output_cnt <= r_output_cnt + img_addr_t'(1);
    end
  end

  assign mem_img_we    = (r_state == s_wait) ? r_img_we : (r_state == s_output && wb_active);
  assign write_mem_img = (r_state == s_output) ? write_result : r_write_img;
  assign mem_img_addr  = (r_state == s_output) ? r_output_offset + r_output_cnt
                                               : r_input_offset + img_addr_t'(r_count_in);

  ////////////////////////////////////////
  // Weight memories and core strobes.
  ////////////////////////////////////////

  always_comb begin
    net_we_dec = '0;
    for (int k = 1; k <= `GOBOU_CORE; k++) begin
      if (net_we == core_sel_t'(k)) net_we_dec[k-1] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_net_we <= '0;
    end else begin
      r_net_we <= r_ack ? net_we_dec : '0;
    end
  end

  always_ff @(posedge clk) begin
    r_write_net <= write_net;
  end

  // Weights and biases of all groups lie back to back.
  always_ff @(posedge clk) begin
    if (!xrst || r_state == s_wait) begin
      r_net_cnt <= '0;
    end else if (r_state == s_weight || r_state == s_bias) begin
      r_net_cnt <= r_net_cnt + net_addr_t'(1);
    end
  end

  assign mem_net_we    = r_net_we;
  assign mem_net_addr  = r_net_offset + r_net_cnt;
  assign write_mem_net = r_write_net;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_core_start <= 1'b0;
      r_core_valid <= 1'b0;
      r_core_stop  <= 1'b0;
      r_ack        <= 1'b1;
    end else begin
      r_core_start <= (r_state == s_wait && run_req) || (s_output_end && !last_group);
      r_core_valid <= r_state == s_weight || r_state == s_bias;
      r_core_stop  <= r_state == s_bias;
      if (run_req) begin
        r_ack <= 1'b0;
      end else if (s_output_end && last_group) begin
        r_ack <= 1'b1;
      end
    end
  end

  assign core_start = r_core_start;
  assign core_valid = r_core_valid;
  assign core_stop  = r_core_stop;
  assign ack        = r_ack;

endmodule

// ==== rtl/gobou_img_mem.sv ====
`timescale 1ns/10ps
`include "gobou_params.svh"

module gobou_img_mem
  import gobou_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  img_addr_t addr,
  input  data_t     wdata,
  output data_t     rdata
);

  data_t r_mem [2**`GOBOU_IMGSIZE];
  data_t r_rdata;

  // One port serves host access, input streaming and write-back.
  always_ff @(posedge clk) begin
    if (we) begin
      r_mem[addr] <= wdata;
    end
    r_rdata <= r_mem[addr];
  end

  assign rdata = r_rdata;

endmodule

// ==== rtl/gobou_params.svh ====
`ifndef GOBOU_PARAMS_SVH
`define GOBOU_PARAMS_SVH

// Signed fixed-point data word with GOBOU_FRAC fraction bits.
`define GOBOU_DWIDTH   16
`define GOBOU_FRAC     8
`define GOBOU_IMGSIZE  10
`define GOBOU_NETSIZE  9
`define GOBOU_LWIDTH   10

// A core number needs GOBOU_CORELOG bits, the core select one more.
`define GOBOU_CORE     4
`define GOBOU_CORELOG  2
`define GOBOU_ACCWIDTH 32

`endif

// ==== rtl/gobou_pkg.sv ====
`include "gobou_params.svh"

package gobou_pkg;

  typedef logic signed [`GOBOU_DWIDTH-1:0]   data_t;
  typedef logic        [`GOBOU_IMGSIZE-1:0]  img_addr_t;
  typedef logic        [`GOBOU_NETSIZE-1:0]  net_addr_t;
  typedef logic        [`GOBOU_LWIDTH-1:0]   len_t;
  // Zero and values above GOBOU_CORE select no core.
  typedef logic        [`GOBOU_CORELOG:0]    core_sel_t;
  typedef logic        [`GOBOU_CORE-1:0]     core_we_t;
  typedef logic signed [`GOBOU_ACCWIDTH-1:0] acc_t;

  typedef enum logic [1:0] {
    s_wait, s_weight, s_bias, s_output
  } ctrl_state_t;

endpackage

// ==== rtl/gobou_serializer.sv ====
`timescale 1ns/10ps
`include "gobou_params.svh"

module gobou_serializer
  import gobou_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 xrst,
  input  logic                                 load,
  input  logic [`GOBOU_CORE*`GOBOU_DWIDTH-1:0] results,
  output data_t                                serial_data
);

  data_t r_slot [`GOBOU_CORE];

  // Slot 0 holds the word that is written back in the current cycle.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `GOBOU_CORE; i++) begin
        r_slot[i] <= '0;
      end
    end else if (load) begin
      for (int i = 0; i < `GOBOU_CORE; i++) begin
        r_slot[i] <= data_t'(results[i*`GOBOU_DWIDTH +: `GOBOU_DWIDTH]);
      end
    end else begin
      for (int i = 0; i < `GOBOU_CORE - 1; i++) begin
        r_slot[i] <= r_slot[i+1];
      end
      r_slot[`GOBOU_CORE-1] <= '0;
    end
  end

  assign serial_data = r_slot[0];

endmodule

// ==== rtl/gobou_top.sv ====
`timescale 1ns/10ps
`include "gobou_params.svh"

module gobou_top
  import gobou_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  logic      req,
  input  logic      img_we,
  input  img_addr_t input_addr,
  input  img_addr_t output_addr,
  input  data_t     write_img,
  input  core_sel_t net_we,
  input  net_addr_t net_addr,
  input  data_t     write_net,
  input  len_t      total_in,
  input  len_t      total_out,
  output logic      ack,
  output data_t     read_img
);

  logic                                 mem_img_we;
  img_addr_t                            mem_img_addr;
  data_t                                write_mem_img;
  core_we_t                             mem_net_we;
  net_addr_t                            mem_net_addr;
  data_t                                write_mem_net;
  logic                                 core_start;
  logic                                 core_valid;
  logic                                 core_stop;
  logic [`GOBOU_CORE-1:0]               core_ready;
  logic [`GOBOU_CORE*`GOBOU_DWIDTH-1:0] core_results;
  data_t                                serial_data;

  gobou_ctrl u_ctrl (
    .clk(clk), .xrst(xrst), .req(req), .img_we(img_we),
    .input_addr(input_addr), .output_addr(output_addr), .write_img(write_img),
    .write_result(serial_data), .result_ready(core_ready[0]),
    .net_we(net_we), .net_addr(net_addr), .write_net(write_net),
    .total_in(total_in), .total_out(total_out), .ack(ack),
    .mem_img_we(mem_img_we), .mem_img_addr(mem_img_addr), .write_mem_img(write_mem_img),
    .mem_net_we(mem_net_we), .mem_net_addr(mem_net_addr), .write_mem_net(write_mem_net),
    .core_start(core_start), .core_valid(core_valid), .core_stop(core_stop)
  );

  gobou_img_mem u_img_mem (
    .clk(clk), .we(mem_img_we), .addr(mem_img_addr), .wdata(write_mem_img), .rdata(read_img)
  );

  for (genvar i = 0; i < `GOBOU_CORE; i++) begin : g_core
    gobou_core u_core (
      .clk(clk), .xrst(xrst), .net_we(mem_net_we[i]), .net_addr(mem_net_addr),
      .write_net(write_mem_net), .img_data(read_img),
      .start(core_start), .valid(core_valid), .stop(core_stop),
      .result(core_results[i*`GOBOU_DWIDTH +: `GOBOU_DWIDTH]), .result_ready(core_ready[i])
    );
  end

  gobou_serializer u_serializer (
    .clk(clk), .xrst(xrst), .load(core_ready[0]), .results(core_results),
    .serial_data(serial_data)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gobou_tb -f sim.f -o gobou_sim
# The testbench exits non-zero on failure, so the log decides the result.
./obj_dir/gobou_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then
  echo "Simulation result: FAIL"
  exit 1
fi
echo "Simulation result: PASS"

// ==== sim.f ====
+incdir+rtl
rtl/gobou_pkg.sv
rtl/gobou_img_mem.sv
rtl/gobou_core.sv
rtl/gobou_serializer.sv
rtl/gobou_ctrl.sv
rtl/gobou_top.sv
testbench/gobou_clkgen.sv
testbench/gobou_chk.sv
testbench/gobou_tb.sv

// ==== testbench/gobou_chk.sv ====
`timescale 1ns/10ps

module gobou_chk
  import gobou_pkg::*;
(
  input logic        clk,
  input logic        xrst,
  input logic        req,
  input logic        ack,
  input ctrl_state_t state,
  input logic        mem_img_we,
  input core_we_t    mem_net_we,
  input logic        core_valid,
  input logic        core_stop
);

  int fail_count = 0;

  a_ack_falls: assert property (@(posedge clk) disable iff (!xrst) (req && ack) |=> !ack)
    else begin
      fail_count++;
      $error("ack did not fall on the cycle after req");
    end

  a_net_we_onehot: assert property (@(posedge clk) disable iff (!xrst) $onehot0(mem_net_we))
    else begin
      fail_count++;
      $error("more than one weight memory write enable is set");
    end

  // Input streaming owns the image port while the cores accumulate.
  a_no_img_write: assert property (@(posedge clk) disable iff (!xrst)
    (state == s_weight || state == s_bias) |-> !mem_img_we)
    else begin
      fail_count++;
      $error("image memory written during s_weight or s_bias");
    end

  a_stop_in_valid: assert property (@(posedge clk) disable iff (!xrst) core_stop |-> core_valid)
    else begin
      fail_count++;
      $error("core_stop asserted without core_valid");
    end

endmodule

// ==== testbench/gobou_clkgen.sv ====
`timescale 1ns/10ps

module gobou_clkgen (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset covers three rising edges and is released on a falling edge.
  initial begin
    xrst = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

// ==== testbench/gobou_tb.sv ====
`timescale 1ns/10ps
`include "gobou_params.svh"

module gobou_tb
  import gobou_pkg::*;
;

  logic      clk;
  logic      xrst;
  logic      req;
  logic      img_we;
  img_addr_t input_addr;
  img_addr_t output_addr;
  data_t     write_img;
  core_sel_t net_we;
  net_addr_t net_addr;
  data_t     write_net;
  len_t      total_in;
  len_t      total_out;
  logic      ack;
  data_t     read_img;

  int unsigned lcg_state = 14743;
  int          error_count = 0;

  // Host-side copies of the image and weight memories.
  data_t img_model [2**`GOBOU_IMGSIZE];
  data_t w_model [`GOBOU_CORE][2**`GOBOU_NETSIZE];

  gobou_clkgen u_clkgen (
    .clk(clk),
    .xrst(xrst)
  );

  gobou_top u_dut (
    .clk(clk), .xrst(xrst), .req(req), .img_we(img_we),
    .input_addr(input_addr), .output_addr(output_addr), .write_img(write_img),
    .net_we(net_we), .net_addr(net_addr), .write_net(write_net),
    .total_in(total_in), .total_out(total_out), .ack(ack), .read_img(read_img)
  );

  bind gobou_ctrl gobou_chk u_chk (
    .clk(clk), .xrst(xrst), .req(req), .ack(ack), .state(r_state),
    .mem_img_we(mem_img_we), .mem_net_we(mem_net_we),
    .core_valid(core_valid), .core_stop(core_stop)
  );

  ////////////////////////////////////////
  // Random data and reference model.
  ////////////////////////////////////////

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic data_t small_value();
    return data_t'(int'(lcg_next() % 256) - 128);
  endfunction

  function automatic int group_count(input int tout);
    return (tout + `GOBOU_CORE - 1) / `GOBOU_CORE;
  endfunction

  // Output n belongs to core n % CORE in group n / CORE.
  function automatic data_t ref_output(input img_addr_t in_off, input net_addr_t net_off,
                                       input int tin, input int n);
    int   k;
    int   base;
    acc_t acc;
    k    = n % `GOBOU_CORE;
    base = int'(net_off) + (n / `GOBOU_CORE) * (tin + 1);
    acc  = '0;
    for (int i = 0; i < tin; i++) begin
      acc += acc_t'(img_model[img_addr_t'(int'(in_off) + i)])
           * acc_t'(w_model[k][net_addr_t'(base + i)]);
    end
    acc += acc_t'(w_model[k][net_addr_t'(base + tin)]) * (2 ** `GOBOU_FRAC);
    return data_t'(acc >>> `GOBOU_FRAC);
  endfunction

  function automatic int test_cycles(input int tin, input int tout);
    int groups;
    groups = group_count(tout);
    // Layer run, weight and input loading, and read-back of results and inputs.
    return (tin + `GOBOU_CORE + 4) * groups + groups * `GOBOU_CORE * (tin + 1) + tin
         + 6 * (groups * `GOBOU_CORE + tin);
  endfunction

  ////////////////////////////////////////
  // Checks.
  ////////////////////////////////////////

  task automatic stop_with_failure();
    error_count++;
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_ack(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // Host access.
  ////////////////////////////////////////

  task automatic write_image(input img_addr_t addr, input data_t value);
    img_we          = 1'b1;
    input_addr      = addr;
    write_img       = value;
    img_model[addr] = value;
    @(negedge clk);
    img_we = 1'b0;
  endtask

  task automatic read_image(input img_addr_t addr, output data_t value);
    input_addr = addr;
    // One cycle registers the address and one reads the memory.
    repeat (2) @(negedge clk);
    value = read_img;
  endtask

  task automatic write_weight(input int core, input net_addr_t addr, input data_t value);
    net_we             = core_sel_t'(core + 1);
    net_addr           = addr;
    write_net          = value;
    w_model[core][addr] = value;
    @(negedge clk);
    net_we = '0;
  endtask

  task automatic load_random_layer(input img_addr_t in_off, input net_addr_t net_off,
                                   input int tin, input int tout);
    for (int i = 0; i < tin; i++) begin
      write_image(in_off + img_addr_t'(i), small_value());
    end
    for (int k = 0; k < `GOBOU_CORE; k++) begin
      for (int j = 0; j < group_count(tout) * (tin + 1); j++) begin
        write_weight(k, net_off + net_addr_t'(j), small_value());
      end
    end
  endtask

  task automatic run_layer(input img_addr_t in_off, input img_addr_t out_off,
                           input net_addr_t net_off, input int tin, input int tout);
    data_t res [$];
    for (int n = 0; n < group_count(tout) * `GOBOU_CORE; n++) begin
      res.push_back(ref_output(in_off, net_off, tin, n));
    end
    req         = 1'b1;
    input_addr  = in_off;
    output_addr = out_off;
    net_addr    = net_off;
    total_in    = len_t'(tin);
    total_out   = len_t'(tout);
    @(negedge clk);
    req = 1'b0;
    check_ack("ack low after req", 1'b0, ack);
    while (ack !== 1'b1) begin
      @(negedge clk);
    end
    // A partial last group still writes a full set of CORE words.
    foreach (res[n]) begin
      img_model[out_off + img_addr_t'(n)] = res[n];
    end
  endtask

  task automatic check_region(input string name, input img_addr_t base, input int count);
    img_addr_t addr;
    data_t     value;
    for (int i = 0; i < count; i++) begin
      addr = base + img_addr_t'(i);
      read_image(addr, value);
      check_data($sformatf("%s word %0d", name, i), img_model[addr], value);
    end
  endtask

  ////////////////////////////////////////
  // Watchdog and assertion monitor.
  ////////////////////////////////////////

  initial begin
    int limit;
    limit = 200 + 9 * 24 + test_cycles(4, 4) + test_cycles(12, 12) + test_cycles(5, 5)
          + test_cycles(6, 8) + test_cycles(6, 4);
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles.", limit);
    stop_with_failure();
  end

  always @(negedge clk) begin
    if (u_dut.u_ctrl.u_chk.fail_count != 0) begin
      $display("A controller assertion failed during the run.");
      stop_with_failure();
    end
  end

  ////////////////////////////////////////
  // Tests.
  ////////////////////////////////////////

  initial begin
    img_addr_t addr;
    data_t     value;
    img_addr_t addr_list [$];
    req         = 1'b0;
    img_we      = 1'b0;
    input_addr  = '0;
    output_addr = '0;
    write_img   = '0;
    net_we      = '0;
    net_addr    = '0;
    write_net   = '0;
    total_in    = '0;
    total_out   = '0;
    while (xrst !== 1'b1) begin
      @(negedge clk);
    end

    check_ack("ack after reset", 1'b1, ack);
    for (int i = 0; i < 8; i++) begin
      addr = img_addr_t'(i * 37 + 3);
      write_image(addr, data_t'({6'b101101, addr}));
    end
    for (int i = 0; i < 8; i++) begin
      addr = img_addr_t'(i * 37 + 3);
      read_image(addr, value);
      check_data("fixed read-back", data_t'({6'b101101, addr}), value);
    end

    for (int i = 0; i < 16; i++) begin
      addr = img_addr_t'(lcg_next());
      addr_list.push_back(addr);
      write_image(addr, data_t'(lcg_next()));
    end
    foreach (addr_list[i]) begin
      read_image(addr_list[i], value);
      check_data($sformatf("random read-back %0d", i), img_model[addr_list[i]], value);
    end

    // Single group with hand-picked inputs, weights and biases.
    for (int i = 0; i < 4; i++) begin
      write_image(img_addr_t'(16 + i), data_t'((i + 1) * 256));
    end
    for (int k = 0; k < `GOBOU_CORE; k++) begin
      for (int i = 0; i < 4; i++) begin
        write_weight(k, net_addr_t'(i), data_t'((k + 1) * 64 - i * 16));
      end
      write_weight(k, net_addr_t'(4), data_t'(k * 128 - 200));
    end
    run_layer(16, 64, 0, 4, 4);
    check_region("single group output", 64, 4);
    check_ack("ack after single group", 1'b1, ack);

    load_random_layer(100, 40, 12, 12);
    run_layer(100, 300, 40, 12, 12);
    check_region("multi group output", 300, 12);
    check_region("multi group input", 100, 12);

    load_random_layer(200, 120, 5, 5);
    run_layer(200, 400, 120, 5, 5);
    check_region("partial group output", 400, 5);

    // The second run overwrites only the upper half of the first run's outputs.
    load_random_layer(500, 200, 6, 8);
    load_random_layer(520, 260, 6, 4);
    run_layer(500, 600, 200, 6, 8);
    run_layer(520, 604, 260, 6, 4);
    check_region("back to back output", 600, 8);
    check_ack("ack after back to back", 1'b1, ack);

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
